// ==== design/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opOp     = 7'b0110011
	} opcode_t;

	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluOr   = 4'd2,
		aluXor  = 4'd3,
		aluAnd  = 4'd4,
		aluSll  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluSlt  = 4'd8,
		aluSltu = 4'd9
	} aluOp_t;

	typedef enum logic [5:0] {
		cuLui, cuAuipc, cuJal, cuJalr,
		cuBeq, cuBne, cuBlt, cuBge, cuBltu, cuBgeu,
		cuLb, cuLh, cuLw, cuLbu, cuLhu, cuSb, cuSh, cuSw,
		cuAddi, cuSlti, cuSltiu, cuXori, cuOri, cuAndi, cuSlli, cuSrli, cuSrai,
		cuAdd, cuSub, cuSll, cuSlt, cuSltu, cuXor, cuSrl, cuSra, cuOr, cuAnd,
		cuError
	} cuOp_t;

	// R/I/S/B layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_t    opcode;
	} regView_t;

	// U/J layout
	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		opcode_t     opcode;
	} upperView_t;

	typedef union packed {
		regView_t   r;
		upperView_t u;
	} instrWord_t;

	typedef struct packed {
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [31:0] imm;
		aluOp_t      aluOp;
		cuOp_t       cuOp;
		logic        regWrite;
		logic        memWrite;
		logic        memRead;
		logic        aluSrc; // Immediate as ALU operand B
		logic        illegal;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] writeData;
		logic [3:0]  byteEnable;
		logic        write;
		logic        read;
	} memReq_t;

endpackage

`default_nettype wire

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  cpuPkg::instrWord_t instr,
	output cpuPkg::ctrl_t      ctrl
);
	import cpuPkg::*;

	logic [31:0] immI, immS, immB, immU, immJ;
	logic        f7Bit30;
	logic        f7Other; // Any funct7 bit besides 30

	assign immI = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
	assign immS = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
	assign immB = {{19{instr.r.funct7[6]}}, instr.r.funct7[6], instr.r.rd[0],
		instr.r.funct7[5:0], instr.r.rd[4:1], 1'b0};
	assign immU = {instr.u.imm20, 12'b0};
	assign immJ = {{11{instr.u.imm20[19]}}, instr.u.imm20[19], instr.u.imm20[7:0],
		instr.u.imm20[8], instr.u.imm20[18:9], 1'b0};

	assign f7Bit30 = instr.r.funct7[5];
	assign f7Other = instr.r.funct7[6] | (|instr.r.funct7[4:0]);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		ctrl.cuOp = cuError;
		case (instr.r.opcode)
			opLui: begin
				ctrl.rd = instr.u.rd;
				ctrl.imm = immU;
				ctrl.aluSrc = 1'b1; // x0 plus imm
				ctrl.regWrite = 1'b1;
				ctrl.cuOp = cuLui;
			end
			opAuipc: begin
				ctrl.rd = instr.u.rd;
				ctrl.imm = immU;
				ctrl.regWrite = 1'b1;
				ctrl.cuOp = cuAuipc;
			end
			opJal: begin
				ctrl.rd = instr.u.rd;
				ctrl.imm = immJ;
				ctrl.regWrite = 1'b1;
				ctrl.cuOp = cuJal;
			end
			opJalr: begin
				ctrl.rs1 = instr.r.rs1;
				ctrl.rd = instr.r.rd;
				ctrl.imm = immI;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				if (instr.r.funct3 == 3'b000)
					ctrl.cuOp = cuJalr;
			end
			opBranch: begin
				ctrl.rs1 = instr.r.rs1;
				ctrl.rs2 = instr.r.rs2;
				ctrl.imm = immB;
				case (instr.r.funct3)
					3'b000: ctrl.cuOp = cuBeq;
					3'b001: ctrl.cuOp = cuBne;
					3'b100: ctrl.cuOp = cuBlt;
					3'b101: ctrl.cuOp = cuBge;
					3'b110: ctrl.cuOp = cuBltu;
					3'b111: ctrl.cuOp = cuBgeu;
					default: ctrl.cuOp = cuError;
				endcase
			end
			opLoad: begin
				ctrl.rs1 = instr.r.rs1;
				ctrl.rd = instr.r.rd;
				ctrl.imm = immI;
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				case (instr.r.funct3)
					3'b000: ctrl.cuOp = cuLb;
					3'b001: ctrl.cuOp = cuLh;
					3'b010: ctrl.cuOp = cuLw;
					3'b100: ctrl.cuOp = cuLbu;
					3'b101: ctrl.cuOp = cuLhu;
					default: ctrl.cuOp = cuError;
				endcase
			end
			opStore: begin
				ctrl.rs1 = instr.r.rs1;
				ctrl.rs2 = instr.r.rs2;
				ctrl.imm = immS;
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				case (instr.r.funct3)
					3'b000: ctrl.cuOp = cuSb;
					3'b001: ctrl.cuOp = cuSh;
					3'b010: ctrl.cuOp = cuSw;
					default: ctrl.cuOp = cuError;
				endcase
			end
			opImm: begin
				ctrl.rs1 = instr.r.rs1;
				ctrl.rd = instr.r.rd;
				ctrl.imm = immI;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				case (instr.r.funct3)
					3'b000: {ctrl.aluOp, ctrl.cuOp} = {aluAdd, cuAddi};
					3'b010: {ctrl.aluOp, ctrl.cuOp} = {aluSlt, cuSlti};
					3'b011: {ctrl.aluOp, ctrl.cuOp} = {aluSltu, cuSltiu};
					3'b100: {ctrl.aluOp, ctrl.cuOp} = {aluXor, cuXori};
					3'b110: {ctrl.aluOp, ctrl.cuOp} = {aluOr, cuOri};
					3'b111: {ctrl.aluOp, ctrl.cuOp} = {aluAnd, cuAndi};
					3'b001: if (!f7Other && !f7Bit30)
						{ctrl.aluOp, ctrl.cuOp} = {aluSll, cuSlli};
					3'b101: if (!f7Other)
						{ctrl.aluOp, ctrl.cuOp} = f7Bit30 ? {aluSra, cuSrai} : {aluSrl, cuSrli};
					default: ctrl.cuOp = cuError;
				endcase
			end
			opOp: begin
				ctrl.rs1 = instr.r.rs1;
				ctrl.rs2 = instr.r.rs2;
				ctrl.rd = instr.r.rd;
				ctrl.regWrite = 1'b1;
				if (!f7Other) begin
					case (instr.r.funct3)
						3'b000: {ctrl.aluOp, ctrl.cuOp} = f7Bit30 ? {aluSub, cuSub} : {aluAdd, cuAdd};
						3'b101: {ctrl.aluOp, ctrl.cuOp} = f7Bit30 ? {aluSra, cuSra} : {aluSrl, cuSrl};
						3'b001: if (!f7Bit30) {ctrl.aluOp, ctrl.cuOp} = {aluSll, cuSll};
						3'b010: if (!f7Bit30) {ctrl.aluOp, ctrl.cuOp} = {aluSlt, cuSlt};
						3'b011: if (!f7Bit30) {ctrl.aluOp, ctrl.cuOp} = {aluSltu, cuSltu};
						3'b100: if (!f7Bit30) {ctrl.aluOp, ctrl.cuOp} = {aluXor, cuXor};
						3'b110: if (!f7Bit30) {ctrl.aluOp, ctrl.cuOp} = {aluOr, cuOr};
						3'b111: if (!f7Bit30) {ctrl.aluOp, ctrl.cuOp} = {aluAnd, cuAnd};
						default: ctrl.cuOp = cuError;
					endcase
				end
			end
			default: ctrl.cuOp = cuError;
		endcase

		// Illegal word does nothing but flag itself
		if (ctrl.cuOp == cuError) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.memRead = 1'b0;
			ctrl.illegal = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic        writeEnable,
	input  logic [31:0] writeData,
	output logic [31:0] readA,
	output logic [31:0] readB
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (writeEnable && rd != 5'd0) begin // x0 stays zero
			regs[rd] <= writeData;
		end
	end

	assign readA = regs[rs1];
	assign readB = regs[rs2];

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input  cpuPkg::aluOp_t op,
	input  logic [31:0]    a,
	input  logic [31:0]    b,
	output logic [31:0]    result
);
	import cpuPkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluOr:   result = a | b;
			aluXor:  result = a ^ b;
			aluAnd:  result = a & b;
			aluSll:  result = a << shamt;
			aluSrl:  result = a >> shamt;
			aluSra:  result = $signed(a) >>> shamt;
			aluSlt:  result = {31'b0, $signed(a) < $signed(b)};
			aluSltu: result = {31'b0, a < b};
			default: result = a + b;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/pcUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
	parameter logic [31:0] resetVector = 32'h0
) (
	input  logic          clk,
	input  logic          reset,
	input  cpuPkg::ctrl_t ctrl,
	input  logic [31:0]   readA,
	input  logic [31:0]   readB,
	input  logic [31:0]   aluResult,
	output logic [31:0]   pc,
	output logic [31:0]   linkValue
);
	import cpuPkg::*;

	logic [31:0] pcPlus4, pcPlusImm, nextPc;
	logic        isEqual, ltSigned, ltUnsigned;
	logic        taken;

	assign pcPlus4 = pc + 32'd4;
	assign pcPlusImm = pc + ctrl.imm;

	assign isEqual = readA == readB;
	assign ltSigned = $signed(readA) < $signed(readB);
	assign ltUnsigned = readA < readB;

	always_comb begin
		case (ctrl.cuOp)
			cuBeq:   taken = isEqual;
			cuBne:   taken = !isEqual;
			cuBlt:   taken = ltSigned;
			cuBge:   taken = !ltSigned;
			cuBltu:  taken = ltUnsigned;
			cuBgeu:  taken = !ltUnsigned;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (ctrl.cuOp == cuJalr)
			nextPc = {aluResult[31:1], 1'b0};
		else if (ctrl.cuOp == cuJal || taken) // Both relative to pc
			nextPc = pcPlusImm;
		else
			nextPc = pcPlus4;
	end

	assign linkValue = (ctrl.cuOp == cuAuipc) ? pcPlusImm : pcPlus4;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= resetVector;
		else
			pc <= nextPc;
	end

endmodule

`default_nettype wire

// ==== design/loadStoreUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
	input  logic            reset,
	input  cpuPkg::ctrl_t   ctrl,
	input  logic [31:0]     address,
	input  logic [31:0]     storeValue,
	input  logic [31:0]     readData,
	output cpuPkg::memReq_t dataReq,
	output logic [31:0]     loadValue
);
	import cpuPkg::*;

	logic [4:0]  laneShift;
	logic [31:0] loadShifted;

	assign laneShift = {address[1:0], 3'b000}; // Byte offset in bits
	assign loadShifted = readData >> laneShift;

	always_comb begin
		dataReq.addr = {address[31:2], 2'b00};
		dataReq.writeData = storeValue << laneShift;
		dataReq.write = ctrl.memWrite & ~reset;
		dataReq.read = ctrl.memRead & ~reset;
		case (ctrl.cuOp)
			cuSb, cuLb, cuLbu: dataReq.byteEnable = 4'b0001 << address[1:0];
			cuSh, cuLh, cuLhu: dataReq.byteEnable = 4'b0011 << {address[1], 1'b0};
			cuSw, cuLw:        dataReq.byteEnable = 4'b1111;
			default:           dataReq.byteEnable = 4'b0000;
		endcase
	end

	always_comb begin
		case (ctrl.cuOp)
			cuLb:    loadValue = {{24{loadShifted[7]}}, loadShifted[7:0]};
			cuLbu:   loadValue = {24'b0, loadShifted[7:0]};
			cuLh:    loadValue = {{16{loadShifted[15]}}, loadShifted[15:0]};
			cuLhu:   loadValue = {16'b0, loadShifted[15:0]};
			default: loadValue = readData;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
	parameter logic [31:0] resetVector = 32'h0
) (
	input  logic            clk,
	input  logic            reset,
	input  logic [31:0]     instruction,
	input  logic [31:0]     readData,
	output logic [31:0]     pc,
	output cpuPkg::memReq_t dataReq,
	output logic            illegalInstr
);
	import cpuPkg::*;

	instrWord_t  instrWord;
	ctrl_t       ctrl;
	logic [31:0] readA, readB;
	logic [31:0] aluB, aluResult;
	logic [31:0] linkValue, loadValue;
	logic [31:0] writeBack;

	assign instrWord = instrWord_t'(instruction);
	assign illegalInstr = ctrl.illegal;

	instrDecoder decoder (.instr(instrWord), .ctrl(ctrl));

	registerFile regFile (
		.clk(clk), .reset(reset),
		.rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd),
		.writeEnable(ctrl.regWrite), .writeData(writeBack),
		.readA(readA), .readB(readB)
	);

	assign aluB = ctrl.aluSrc ? ctrl.imm : readB;

	aluUnit alu (.op(ctrl.aluOp), .a(readA), .b(aluB), .result(aluResult));

	pcUnit #(.resetVector(resetVector)) pcGen (
		.clk(clk), .reset(reset), .ctrl(ctrl),
		.readA(readA), .readB(readB), .aluResult(aluResult),
		.pc(pc), .linkValue(linkValue)
	);

	loadStoreUnit lsu (
		.reset(reset), .ctrl(ctrl), .address(aluResult), .storeValue(readB),
		.readData(readData), .dataReq(dataReq), .loadValue(loadValue)
	);

	always_comb begin
		case (ctrl.cuOp)
			cuLb, cuLh, cuLw, cuLbu, cuLhu: writeBack = loadValue;
			cuJal, cuJalr, cuAuipc:         writeBack = linkValue; // Return address or pc+imm
			default:                        writeBack = aluResult;
		endcase
	end

endmodule

`default_nettype wire

// ==== test/cpuCore_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore_chk (
	input logic            clk,
	input logic            reset,
	input logic [31:0]     pc,
	input cpuPkg::memReq_t dataReq
);

	strobeExclusive: assert property (@(posedge clk) !(dataReq.write && dataReq.read))
		else $error("write and read strobes high together");

	quietInReset: assert property (@(posedge clk) reset |-> !dataReq.write && !dataReq.read)
		else $error("memory strobe active during reset");

	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc not word aligned");

endmodule

bind cpuCore cpuCore_chk chk (.clk(clk), .reset(reset), .pc(pc), .dataReq(dataReq));

`default_nettype wire

// ==== test/cpuModel.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
	logic [4:0] rd, logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
	logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
	logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
	logic [31:0] b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'b0, $signed(a) < $signed(b)};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

// Executes one word on the model state and sets the expected strobes
function automatic void modelStep(input logic [31:0] w);
	logic [6:0]  opc, f7;
	logic [4:0]  rd, rs1, rs2;
	logic [2:0]  f3;
	logic [31:0] a, b, immI, immS, immB, immU, immJ, res, addr, nextPc, word, data;
	logic [3:0]  be;
	logic        wr, legal, taken;
	opc = w[6:0];
	rd = w[11:7];
	f3 = w[14:12];
	rs1 = w[19:15];
	rs2 = w[24:20];
	f7 = w[31:25];
	a = mRegs[rs1];
	b = mRegs[rs2];
	immI = {{20{w[31]}}, w[31:20]};
	immS = {{20{w[31]}}, w[31:25], w[11:7]};
	immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	immU = {w[31:12], 12'b0};
	immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
	nextPc = mPc + 32'd4;
	res = '0;
	wr = 1'b0;
	legal = 1'b1;
	taken = 1'b0;
	be = 4'b0;
	expReq = '0;
	case (opc)
		7'b0110111: {res, wr} = {immU, 1'b1};
		7'b0010111: {res, wr} = {mPc + immU, 1'b1};
		7'b1101111: begin
			{res, wr} = {mPc + 32'd4, 1'b1};
			nextPc = mPc + immJ;
		end
		7'b1100111: begin
			legal = f3 == 3'd0;
			{res, wr} = {mPc + 32'd4, 1'b1};
			if (legal) nextPc = (a + immI) & ~32'd1;
		end
		7'b1100011: begin
			case (f3)
				3'd0: taken = a == b;
				3'd1: taken = a != b;
				3'd4: taken = $signed(a) < $signed(b);
				3'd5: taken = $signed(a) >= $signed(b);
				3'd6: taken = a < b;
				3'd7: taken = a >= b;
				default: legal = 1'b0;
			endcase
			if (taken) nextPc = mPc + immB;
		end
		7'b0000011: begin
			addr = a + immI;
			word = {mMem[{addr[9:2], 2'd3}], mMem[{addr[9:2], 2'd2}],
				mMem[{addr[9:2], 2'd1}], mMem[{addr[9:2], 2'd0}]};
			word = word >> {addr[1:0], 3'b000};
			case (f3)
				3'd0: {res, be} = {{{24{word[7]}}, word[7:0]}, 4'b0001 << addr[1:0]};
				3'd1: {res, be} = {{{16{word[15]}}, word[15:0]}, 4'b0011 << addr[1:0]};
				3'd2: {res, be} = {word, 4'b1111};
				3'd4: {res, be} = {{24'b0, word[7:0]}, 4'b0001 << addr[1:0]};
				3'd5: {res, be} = {{16'b0, word[15:0]}, 4'b0011 << addr[1:0]};
				default: legal = 1'b0;
			endcase
			wr = 1'b1;
			expReq.read = 1'b1;
			expReq.addr = {addr[31:2], 2'b00};
			expReq.byteEnable = be;
		end
		7'b0100011: begin
			addr = a + immS;
			data = b << {addr[1:0], 3'b000};
			case (f3)
				3'd0: be = 4'b0001 << addr[1:0];
				3'd1: be = 4'b0011 << addr[1:0];
				3'd2: be = 4'b1111;
				default: legal = 1'b0;
			endcase
			for (int k = 0; k < 4; k++)
				if (legal && be[k]) mMem[{addr[9:2], 2'(k)}] = data[8*k +: 8];
			expReq = '{addr: {addr[31:2], 2'b00}, writeData: data, byteEnable: be,
				write: 1'b1, read: 1'b0};
		end
		7'b0010011: begin
			if ((f3 == 3'd1 && f7 != 7'h0) || (f3 == 3'd5 && f7 != 7'h0 && f7 != 7'h20))
				legal = 1'b0;
			{res, wr} = {aluRef(f3, f3 == 3'd5 && f7[5], a, immI), 1'b1};
		end
		7'b0110011: begin
			if (f7 != 7'h0 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
				legal = 1'b0;
			{res, wr} = {aluRef(f3, f7[5], a, b), 1'b1};
		end
		default: legal = 1'b0;
	endcase
	if (!legal) begin // Nothing but the flag and pc plus four
		wr = 1'b0;
		expReq = '0;
		nextPc = mPc + 32'd4;
	end
	expIllegal = !legal;
	if (wr && rd != 5'd0) mRegs[rd] = res;
	mPc = nextPc;
endfunction

`endif

// ==== test/cpuCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;
	import cpuPkg::*;

	localparam logic [31:0] resetVector = 32'h80;
	localparam int numTests = 5;
	localparam logic [31:0] selfLoop = 32'h0000006f; // JAL x0, 0
	localparam logic [31:0] resetStore = 32'h00002023; // SW x0, 0(x0)

	logic        clk, reset;
	logic [31:0] instruction, readData, pc;
	memReq_t     dataReq;
	logic        illegalInstr;

	logic [31:0] imem [256];
	logic [7:0]  dmem [1024];
	logic [31:0] progs [numTests][256];
	int          progLen [numTests];
	logic [31:0] mRegs [32];
	logic [7:0]  mMem [1024];
	logic [31:0] mPc;
	memReq_t     expReq;
	logic        expIllegal;
	logic [31:0] rngState = 32'he1a2;
	int          errorCount = 0, passCount = 0, failCount = 0;
	int          cycles = 0, cycleLimit = 0;

	`include "cpuModel.svh"

	cpuCore #(.resetVector(resetVector)) dut (
		.clk(clk), .reset(reset), .instruction(instruction), .readData(readData),
		.pc(pc), .dataReq(dataReq), .illegalInstr(illegalInstr)
	);

	assign instruction = imem[pc[9:2]];
	assign readData = {dmem[{dataReq.addr[9:2], 2'd3}], dmem[{dataReq.addr[9:2], 2'd2}],
		dmem[{dataReq.addr[9:2], 2'd1}], dmem[{dataReq.addr[9:2], 2'd0}]};

	always @(posedge clk) begin
		if (dataReq.write)
			for (int i = 0; i < 4; i++)
				if (dataReq.byteEnable[i])
					dmem[{dataReq.addr[9:2], 2'(i)}] <= dataReq.writeData[8*i +: 8];
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic logic [7:0] fillByte(int i);
		return 8'(i * 29 + (i >> 8) * 113 + 7); // Whole address feeds the pattern
	endfunction

	function automatic void addInstr(int t, logic [31:0] w);
		progs[t][progLen[t]] = w;
		progLen[t]++;
	endfunction

	function automatic logic [31:0] illegalWord(logic [31:0] x);
		case (x[1:0])
			2'd0: return {x[31:15], 1'b1, x[13:12], x[11:7], 7'b0100011}; // Store, funct3 4 to 7
			2'd1: return {x[31:15], x[14], 2'b11, x[11:7], 7'b0000011}; // Load, funct3 3 or 7
			2'd2: return {x[31:15], 1'b1, x[13:12], x[11:7], 7'b1100111}; // JALR, funct3 not 0
			default: return {x[31:7], 7'b1111111};
		endcase
	endfunction

	function automatic void seedRegs(int t, int first, int last);
		logic [31:0] upper;
		for (int r = first; r <= last; r++) begin
			upper = nextRand();
			addInstr(t, {upper[19:0], 5'(r), 7'b0110111});
			addInstr(t, encI(12'(nextRand()), 5'(r), 3'd0, 5'(r), 7'b0010011));
		end
	endfunction

	function automatic void genAlu(int t, bit withIllegal);
		logic [31:0] r, s;
		logic [2:0]  f3;
		seedRegs(t, 1, 31);
		for (int n = 0; n < 40; n++) begin
			r = nextRand();
			s = nextRand();
			f3 = r[2:0];
			if (withIllegal && s[31:29] == 3'd0)
				addInstr(t, illegalWord(nextRand()));
			if (r[3])
				addInstr(t, {(r[4] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h0,
					s[4:0], s[9:5], f3, s[14:10], 7'b0110011});
			else if (f3 == 3'd1 || f3 == 3'd5)
				addInstr(t, encI({(r[4] && f3 == 3'd5) ? 7'h20 : 7'h0, s[24:20]},
					s[9:5], f3, s[14:10], 7'b0010011));
			else
				addInstr(t, encI(s[31:20], s[9:5], f3, s[14:10], 7'b0010011));
		end
		for (int q = 0; q < 32; q++)
			addInstr(t, encS(12'(4 * q), 5'(q), 5'd0, 3'd2));
		addInstr(t, selfLoop);
	endfunction

	function automatic void genMem(int t);
		logic [31:0] r;
		logic [2:0]  f3;
		logic [9:0]  off;
		seedRegs(t, 1, 8);
		for (int n = 0; n < 30; n++) begin
			r = nextRand();
			off = r[17:8];
			if (r[0]) begin
				f3 = 3'(r[3:2] % 3);
				off = (f3 == 3'd2) ? off & ~10'd3 : (f3 == 3'd1 ? off & ~10'd1 : off);
				addInstr(t, encS({2'b0, off}, 5'(1 + r[22:20]), 5'd0, f3));
			end else begin
				case (r[3:1] % 5)
					0: f3 = 3'd0;
					1: f3 = 3'd1;
					2: f3 = 3'd2;
					3: f3 = 3'd4;
					default: f3 = 3'd5;
				endcase
				off = (f3 == 3'd2) ? off & ~10'd3 : (f3[0] ? off & ~10'd1 : off);
				addInstr(t, encI({2'b0, off}, 5'd0, f3, 5'(9 + r[30:28] % 7), 7'b0000011));
				addInstr(t, encS({2'b0, r[27:20], 2'b00}, 5'(9 + r[30:28] % 7), 5'd0, 3'd2));
			end
		end
		addInstr(t, selfLoop);
	endfunction

	function automatic void genCtrl(int t);
		logic [31:0] r;
		int          slot;
		int          kind;
		slot = 0;
		seedRegs(t, 1, 4);
		addInstr(t, encI(12'd0, 5'd1, 3'd0, 5'd2, 7'b0010011)); // x2 equals x1
		for (int n = 0; n < 18; n++) begin
			r = nextRand();
			kind = n / 3; // Each branch kind once
			case (n % 3)
				0: begin
					addInstr(t, encB(13'd12, 5'(1 + r[5:4]), 5'(1 + r[7:6]),
						(kind < 2) ? 3'(kind) : 3'(kind + 2)));
					addInstr(t, encI(12'd1, 5'd7, 3'd0, 5'd7, 7'b0010011));
					addInstr(t, encI(12'd2, 5'd7, 3'd0, 5'd7, 7'b0010011));
					addInstr(t, encS(12'(4 * slot), 5'd7, 5'd0, 3'd2));
					slot++;
				end
				1: begin
					addInstr(t, encJ(21'd8, 5'd8));
					addInstr(t, encI(12'd5, 5'd7, 3'd0, 5'd7, 7'b0010011));
					addInstr(t, encS(12'(4 * slot), 5'd8, 5'd0, 3'd2));
					slot++;
				end
				default: begin
					addInstr(t, {20'd0, 5'd5, 7'b0010111});
					addInstr(t, encI(12'd16, 5'd5, 3'd0, 5'd9, 7'b1100111));
					addInstr(t, encI(12'd3, 5'd7, 3'd0, 5'd7, 7'b0010011));
					addInstr(t, encI(12'd4, 5'd7, 3'd0, 5'd7, 7'b0010011));
					addInstr(t, encS(12'(4 * slot), 5'd9, 5'd0, 3'd2));
					addInstr(t, encS(12'(4 * slot + 4), 5'd5, 5'd0, 3'd2));
					slot += 2;
				end
			endcase
		end
		addInstr(t, selfLoop);
	endfunction

	task automatic reportFail(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		errorCount++;
	endtask

	task automatic checkPc(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			reportFail($sformatf("pc is %h, expected %h", got, exp));
	endtask

	task automatic checkFlag(input logic got, input logic exp);
		if (got !== exp)
			reportFail($sformatf("illegalInstr is %b, expected %b at pc %h", got, exp, pc));
	endtask

	task automatic checkWrite(input memReq_t got, input memReq_t exp);
		logic [31:0] mask;
		for (int i = 0; i < 4; i++)
			mask[8*i +: 8] = {8{exp.byteEnable[i]}};
		if (got.write !== exp.write || got.read !== exp.read)
			reportFail($sformatf("strobes write/read %b%b, expected %b%b at pc %h",
				got.write, got.read, exp.write, exp.read, pc));
		else if ((exp.write || exp.read) &&
			(got.addr !== exp.addr || got.byteEnable !== exp.byteEnable))
			reportFail($sformatf("access %h/%b, expected %h/%b", got.addr, got.byteEnable,
				exp.addr, exp.byteEnable));
		else if (exp.write && (got.writeData & mask) !== (exp.writeData & mask))
			reportFail($sformatf("store data %h, expected %h under mask %h",
				got.writeData, exp.writeData, mask));
	endtask

	task automatic runTest(input int t, input string name);
		int          errsBefore;
		logic [31:0] w;
		bit          done;
		errsBefore = errorCount;
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		for (int i = 0; i < 256; i++)
			imem[i] = resetStore; // Store that reset must hold back
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = fillByte(i);
			mMem[i] = fillByte(i);
		end
		for (int i = 0; i < 32; i++)
			mRegs[i] = '0;
		mPc = resetVector;
		repeat (15) @(posedge clk);
		@(negedge clk);
		for (int i = 0; i < 256; i++)
			imem[i] = selfLoop;
		for (int i = 0; i < progLen[t]; i++)
			imem[resetVector[9:2] + 8'(i)] = progs[t][i];
		@(posedge clk);
		reset <= 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			w = imem[mPc[9:2]];
			checkPc(pc, mPc);
			modelStep(w);
			checkFlag(illegalInstr, expIllegal);
			checkWrite(dataReq, expReq);
			done = w == selfLoop;
		end
		if (errorCount == errsBefore) begin
			passCount++;
			$display("Test %0d %s: passed", t + 1, name);
		end else begin
			failCount++;
			$display("Test %0d %s: failed", t + 1, name);
		end
	endtask

	initial begin
		reset = 1'b1;
		for (int i = 0; i < 256; i++)
			imem[i] = resetStore;
		for (int i = 0; i < 1024; i++)
			dmem[i] = fillByte(i);
		for (int t = 0; t < numTests; t++)
			progLen[t] = 0;
		addInstr(0, encI(12'd0, 5'd0, 3'd0, 5'd0, 7'b0010011)); // nop
		addInstr(0, selfLoop);
		genAlu(1, 1'b0);
		genMem(2);
		genCtrl(3);
		genAlu(4, 1'b1);
		cycleLimit = 200;
		for (int t = 0; t < numTests; t++)
			cycleLimit += progLen[t] + 16;
		runTest(0, "reset");
		runTest(1, "alu");
		runTest(2, "load/store");
		runTest(3, "branch/jump");
		runTest(4, "illegal");
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		forever begin
			@(posedge clk);
			cycles++;
			if (cycleLimit > 0 && cycles > cycleLimit) begin
				$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
				$display("SOME TESTS FAILED");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+test
design/cpuPkg.sv
design/instrDecoder.sv
design/registerFile.sv
design/aluUnit.sv
design/pcUnit.sv
design/loadStoreUnit.sv
design/cpuCore.sv
test/cpuCore_chk.sv
test/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the cpuCore testbench with Verilator

verilator --binary --timing --assert --top-module cpuCoreTb -f src.f -o simCpuCore > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/simCpuCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
exit 1
